/* rtl/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first address fetched out of reset
`define RESET_PC 32'hbfc0_0000

// general exception vector
`define EXC_ENTRY 32'hbfc0_0380

// one instruction pair per fetch
`define FETCH_STRIDE 32'd8

// slot 0 sits one word above slot 1
`define SLOT_STRIDE 32'd4

`endif

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    // address or instruction word
    typedef logic [31:0] word_t;

    // fetch response, low word is slot 1, high word is slot 0
    typedef logic [63:0] pair_t;

    // redirect sources, encoded so a larger value wins
    typedef enum logic [2:0] {
        REDIRECT_NONE   = 3'd0,
        REDIRECT_PRED   = 3'd1,
        REDIRECT_BRANCH = 3'd2,
        REDIRECT_ERET   = 3'd3,
        REDIRECT_EXC    = 3'd4
    } redirect_e;

    // per-slot fetch status
    typedef enum logic {
        FETCH_OK       = 1'b0,
        FETCH_ADDR_ERR = 1'b1
    } fetch_exc_e;

endpackage

/* rtl/pc_sequencer.sv */
`include "fetch_consts.svh"

module pc_sequencer
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  exc_taken,
    input  logic  eret,
    input  logic  branch_taken,
    input  logic  pred_taken,
    input  word_t epc,
    input  word_t branch_target,
    input  word_t pred_target,
    output word_t fetch_pc,
    output logic  fetch_misaligned
);

    // redirect requested in this cycle
    redirect_e cur_kind;
    word_t     cur_target;

    // strongest redirect seen while stalled
    redirect_e saved_kind;
    word_t     saved_target;

    word_t     pc_next;

    // classify the incoming pulses, highest priority first
    always_comb begin
        cur_kind   = REDIRECT_NONE;
        cur_target = '0;
        if (exc_taken) begin
            cur_kind   = REDIRECT_EXC;
            cur_target = `EXC_ENTRY;
        end else if (eret) begin
            cur_kind   = REDIRECT_ERET;
            cur_target = epc;
        end else if (branch_taken) begin
            cur_kind   = REDIRECT_BRANCH;
            cur_target = branch_target;
        end else if (pred_taken) begin
            cur_kind   = REDIRECT_PRED;
            cur_target = pred_target;
        end
    end

    // saved redirect wins unless a stronger one arrives now
    always_comb begin
        if (cur_kind > saved_kind) begin
            pc_next = cur_target;
        end else if (saved_kind != REDIRECT_NONE) begin
            pc_next = saved_target;
        end else begin
            // plain sequential pair step
            pc_next = fetch_pc + `FETCH_STRIDE;
        end
    end

    // kind of the saved redirect
    // only upgrades during a stall, cleared once fetch moves
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_kind <= REDIRECT_NONE;
        end else if (!stall) begin
            saved_kind <= REDIRECT_NONE;
        end else if (cur_kind > saved_kind) begin
            saved_kind <= cur_kind;
        end
    end

    // target follows the kind
    always_ff @(posedge clk) begin
        if (stall && (cur_kind > saved_kind)) begin
            saved_target <= cur_target;
        end
    end

    // fetch pc, frozen under stall
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= `RESET_PC;
        end else if (!stall) begin
            fetch_pc <= pc_next;
        end
    end

    // low address bits must be zero for a word fetch
    assign fetch_misaligned = |fetch_pc[1:0];

    // a saved redirect is consumed by the first unstalled edge
    saved_consumed: assert property (
        @(posedge clk) disable iff (reset)
        !stall |=> saved_kind == REDIRECT_NONE
    );

endmodule

/* rtl/fetch_word_hold.sv */
module fetch_word_hold
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  pair_t iresp_data,
    output logic  held_valid,
    output pair_t held_pair
);

    // first stalled cycle carries the real response
    logic capture;

    assign capture = stall && !held_valid;

    // hold flag, drops on the first edge with stall low
    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (capture) begin
            held_valid <= 1'b1;
        end else if (!stall) begin
            held_valid <= 1'b0;
        end
    end

    // memory data may wander while the address repeats
    always_ff @(posedge clk) begin
        if (capture) begin
            held_pair <= iresp_data;
        end
    end

    // held response stays put for the whole stall
    held_stable: assert property (
        @(posedge clk) disable iff (reset)
        held_valid ##1 held_valid |-> $stable(held_pair)
    );

endmodule

/* rtl/fetch_slot_pack.sv */
`include "fetch_consts.svh"

module fetch_slot_pack
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  logic       fetch_misaligned,
    input  logic       held_valid,
    input  word_t      fetch_pc,
    input  pair_t      iresp_data,
    input  pair_t      held_pair,
    output logic       slot_valid,
    output fetch_exc_e slot_exc,
    output word_t      slot1_pc,
    output word_t      slot1_instr,
    output word_t      slot0_pc,
    output word_t      slot0_instr
);

    // flush seen at the last accepting edge
    logic  flush_d;
    // response in use this cycle
    pair_t pair;

    // fetch-1 register, loads on every accepting edge
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
            slot_exc   <= FETCH_OK;
            flush_d    <= 1'b0;
            slot1_pc   <= '0;
            slot0_pc   <= '0;
        end else if (!stall) begin
            slot_valid <= !flush;
            // a squashed fetch reports no exception
            slot_exc   <= (fetch_misaligned && !flush) ? FETCH_ADDR_ERR : FETCH_OK;
            flush_d    <= flush;
            slot1_pc   <= fetch_pc;
            slot0_pc   <= fetch_pc + `SLOT_STRIDE;
        end
    end

    // captured copy beats the live bus
    assign pair = held_valid ? held_pair : iresp_data;

    // slot 1, low word
    // zero for a squashed or misaligned fetch
    always_comb begin
        if (flush_d || (slot_exc == FETCH_ADDR_ERR)) begin
            slot1_instr = '0;
        end else begin
            slot1_instr = pair[31:0];
        end
    end

    // slot 0, high word
    always_comb begin
        if (flush_d) begin
            slot0_instr = '0;
        end else begin
            slot0_instr = pair[63:32];
        end
    end

    // no exception on an empty slot pair
    exc_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        !slot_valid |-> slot_exc == FETCH_OK
    );

endmodule

/* rtl/fetch_front.sv */
module fetch_front
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  logic       exc_taken,
    input  logic       eret,
    input  word_t      epc,
    input  logic       branch_taken,
    input  word_t      branch_target,
    input  logic       pred_taken,
    input  word_t      pred_target,
    input  pair_t      iresp_data,
    output word_t      ireq_addr,
    output logic       ireq_valid,
    output logic       slot_valid,
    output fetch_exc_e slot_exc,
    output word_t      slot1_pc,
    output word_t      slot1_instr,
    output word_t      slot0_pc,
    output word_t      slot0_instr
);

    word_t fetch_pc;
    logic  fetch_misaligned;
    logic  held_valid;
    pair_t held_pair;

    // pc stage
    pc_sequencer u_pc_sequencer (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .exc_taken        (exc_taken),
        .eret             (eret),
        .branch_taken     (branch_taken),
        .pred_taken       (pred_taken),
        .epc              (epc),
        .branch_target    (branch_target),
        .pred_target      (pred_target),
        .fetch_pc         (fetch_pc),
        .fetch_misaligned (fetch_misaligned)
    );

    // request goes out straight from the pc register
    assign ireq_addr  = fetch_pc;
    // no bus request for a misaligned pc
    assign ireq_valid = !fetch_misaligned;

    // response capture across stalls
    fetch_word_hold u_fetch_word_hold (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .iresp_data (iresp_data),
        .held_valid (held_valid),
        .held_pair  (held_pair)
    );

    // fetch-1 register and slot assembly
    fetch_slot_pack u_fetch_slot_pack (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .flush            (flush),
        .fetch_misaligned (fetch_misaligned),
        .held_valid       (held_valid),
        .fetch_pc         (fetch_pc),
        .iresp_data       (iresp_data),
        .held_pair        (held_pair),
        .slot_valid       (slot_valid),
        .slot_exc         (slot_exc),
        .slot1_pc         (slot1_pc),
        .slot1_instr      (slot1_instr),
        .slot0_pc         (slot0_pc),
        .slot0_instr      (slot0_instr)
    );

endmodule

/* sim/fetch_checker.sv */
`include "fetch_consts.svh"

module fetch_checker
    import fetch_pkg::*;
#(
    parameter word_t mem_pattern = 32'h0
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  word_t      ireq_addr,
    input  logic       ireq_valid,
    input  logic       slot_valid,
    input  fetch_exc_e slot_exc,
    input  word_t      slot1_pc,
    input  word_t      slot1_instr,
    input  word_t      slot0_pc,
    input  word_t      slot0_instr,
    input  logic       row_active,
    input  int         row_test,
    input  word_t      row_exp_addr,
    output int         error_count,
    output int         tests_passed,
    output int         tests_failed
);

    // address check runs one row behind the stimulus
    logic  pend_valid;
    int    pend_test;
    word_t pend_addr;
    int    test_errors;

    // slot contents expected in this cycle
    logic  exp_valid;
    logic  exp_flush;
    logic  exp_mis;
    word_t exp_pc;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic close_test(input int test);
        if (test_errors == 0) begin
            $display("test %0d passed", test);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic check_slots();
        fetch_exc_e exp_exc;
        exp_exc = (exp_valid && exp_mis) ? FETCH_ADDR_ERR : FETCH_OK;
        check_value("slot_valid", 32'(exp_valid), 32'(slot_valid));
        check_value("slot_exc", 32'(exp_exc), 32'(slot_exc));
        if (exp_valid) begin
            check_value("slot1_pc", exp_pc, slot1_pc);
            check_value("slot0_pc", exp_pc + `SLOT_STRIDE, slot0_pc);
            // misaligned fetch carries no slot 1 word
            check_value("slot1_instr", exp_mis ? 32'h0 : exp_pc ^ mem_pattern, slot1_instr);
            check_value("slot0_instr", (exp_pc + 32'd4) ^ mem_pattern, slot0_instr);
        end else if (exp_flush) begin
            check_value("slot1_instr", 32'h0, slot1_instr);
            check_value("slot0_instr", 32'h0, slot0_instr);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            error_count  = 0;
            tests_passed = 0;
            tests_failed = 0;
            test_errors  = 0;
            // first test also covers the reset address
            pend_valid   = 1'b1;
            pend_test    = 1;
            pend_addr    = `RESET_PC;
            exp_valid    = 1'b0;
            exp_flush    = 1'b0;
            exp_mis      = 1'b0;
            exp_pc       = '0;
        end else begin
            if (pend_valid) begin
                check_value("ireq_addr", pend_addr, ireq_addr);
                // request only for a word aligned address
                check_value("ireq_valid", 32'(pend_addr[1:0] == 2'b00), 32'(ireq_valid));
            end
            check_slots();
            if (pend_valid && (!row_active || row_test != pend_test)) begin
                close_test(pend_test);
            end
            // accepted fetch reaches the slots next cycle
            if (!stall && pend_valid) begin
                exp_valid = !flush;
                exp_flush = flush;
                exp_mis   = pend_addr[1:0] != 2'b00;
                exp_pc    = pend_addr;
            end
            pend_valid = row_active;
            pend_test  = row_test;
            pend_addr  = row_exp_addr;
        end
    end

endmodule

/* sim/tb_fetch_front.sv */
`include "fetch_consts.svh"

module tb_fetch_front
    import fetch_pkg::*;
();

    // memory word is its address scrambled by this pattern
    localparam word_t mem_pattern    = 32'h5a5a_a5a5;
    localparam word_t epc_addr       = 32'h8000_1000;
    localparam word_t pred_addr      = 32'h8000_3000;
    // cycles allowed on top of one per table row
    localparam int    timeout_margin = 20;

    // control bits of a row: stall flush exc eret branch pred
    localparam logic [5:0] ctl_none   = 6'b000000;
    localparam logic [5:0] ctl_stall  = 6'b100000;
    localparam logic [5:0] ctl_flush  = 6'b010000;
    localparam logic [5:0] ctl_exc    = 6'b001000;
    localparam logic [5:0] ctl_eret   = 6'b000100;
    localparam logic [5:0] ctl_branch = 6'b000010;
    localparam logic [5:0] ctl_pred   = 6'b000001;

    typedef struct packed {
        int         test;
        logic [5:0] ctrl;
        word_t      btgt;
        word_t      exp_addr;
    } step_t;

    logic       clk;
    logic       reset;
    logic       stall;
    logic       flush;
    logic       exc_taken;
    logic       eret;
    logic       branch_taken;
    logic       pred_taken;
    word_t      epc;
    word_t      branch_target;
    word_t      pred_target;
    pair_t      iresp_data;
    word_t      ireq_addr;
    logic       ireq_valid;
    logic       slot_valid;
    fetch_exc_e slot_exc;
    word_t      slot1_pc;
    word_t      slot1_instr;
    word_t      slot0_pc;
    word_t      slot0_instr;

    // row being applied, seen by the checker
    logic  row_active;
    int    row_test;
    word_t row_exp_addr;

    int     error_count;
    int     tests_passed;
    int     tests_failed;
    step_t  steps[$];
    int     row_count;
    int     cycle_count;
    integer seed;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic word_t mem_word(input word_t addr);
        return addr ^ mem_pattern;
    endfunction

    // memory answers one cycle after the address
    // junk while stalled, so only the held copy is usable
    always @(posedge clk) begin
        if (stall) begin
            iresp_data <= {$random(seed), $random(seed)};
        end else begin
            iresp_data <= {mem_word(ireq_addr + 32'd4), mem_word(ireq_addr)};
        end
    end

    fetch_front dut0 (.*);

    fetch_checker #(.mem_pattern(mem_pattern)) chk0 (.*);

    task automatic add_step(input int test, input logic [5:0] ctrl, input word_t btgt,
                            input word_t exp_addr);
        steps.push_back(step_t'{test, ctrl, btgt, exp_addr});
    endtask

    // expected address is ireq_addr after the row's edge
    task automatic build_table();
        add_step(1, ctl_none, '0, `RESET_PC + `FETCH_STRIDE);
        add_step(1, ctl_none, '0, `RESET_PC + 32'd16);
        add_step(1, ctl_none, '0, `RESET_PC + 32'd24);
        // all four sources, then dropped one by one
        add_step(2, ctl_exc | ctl_eret | ctl_branch | ctl_pred, 32'h8000_2000, `EXC_ENTRY);
        add_step(2, ctl_eret | ctl_branch | ctl_pred, 32'h8000_2000, epc_addr);
        add_step(2, ctl_branch | ctl_pred, 32'h8000_2000, 32'h8000_2000);
        add_step(2, ctl_pred, '0, pred_addr);
        add_step(2, ctl_none, '0, pred_addr + `FETCH_STRIDE);
        // branch saved under stall
        add_step(3, ctl_stall | ctl_branch, 32'h8000_4000, 32'h8000_3008);
        add_step(3, ctl_stall, '0, 32'h8000_3008);
        add_step(3, ctl_none, '0, 32'h8000_4000);
        add_step(3, ctl_none, '0, 32'h8000_4008);
        // exception upgrades the saved branch, weaker pred loses
        add_step(3, ctl_stall | ctl_branch, 32'h8000_5000, 32'h8000_4008);
        add_step(3, ctl_stall | ctl_exc, '0, 32'h8000_4008);
        add_step(3, ctl_pred, '0, `EXC_ENTRY);
        add_step(3, ctl_none, '0, `EXC_ENTRY + `FETCH_STRIDE);
        // long stall against a noisy bus
        add_step(4, ctl_stall, '0, `EXC_ENTRY + `FETCH_STRIDE);
        add_step(4, ctl_stall, '0, `EXC_ENTRY + `FETCH_STRIDE);
        add_step(4, ctl_stall, '0, `EXC_ENTRY + `FETCH_STRIDE);
        add_step(4, ctl_none, '0, `EXC_ENTRY + 32'd16);
        add_step(4, ctl_none, '0, `EXC_ENTRY + 32'd24);
        add_step(5, ctl_branch, 32'h8000_7002, 32'h8000_7002);
        add_step(5, ctl_none, '0, 32'h8000_700a);
        add_step(5, ctl_branch, 32'h8000_8000, 32'h8000_8000);
        add_step(5, ctl_none, '0, 32'h8000_8008);
        add_step(6, ctl_flush, '0, 32'h8000_8010);
        add_step(6, ctl_none, '0, 32'h8000_8018);
        add_step(6, ctl_none, '0, 32'h8000_8020);
        row_count = steps.size();
    endtask

    task automatic drive_row(input logic [5:0] ctrl, input word_t btgt);
        {stall, flush, exc_taken, eret, branch_taken, pred_taken} = ctrl;
        branch_target = btgt;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        seed         = 78526;
        cycle_count  = 0;
        row_count    = 0;
        iresp_data   = '0;
        epc          = epc_addr;
        pred_target  = pred_addr;
        row_active   = 1'b0;
        row_test     = 0;
        row_exp_addr = '0;
        drive_row(ctl_none, '0);
        build_table();
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        for (int i = 0; i < row_count; i++) begin
            drive_row(steps[i].ctrl, steps[i].btgt);
            row_active   = 1'b1;
            row_test     = steps[i].test;
            row_exp_addr = steps[i].exp_addr;
            @(posedge clk);
            #5;
        end
        // one idle cycle lets the checker close the last test
        drive_row(ctl_none, '0);
        row_active = 1'b0;
        @(negedge clk);
        #1;
        $display("summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (row_count > 0);
        wait (cycle_count >= row_count + timeout_margin);
        $display("timeout: run did not finish within %0d cycles", cycle_count);
        $display("tests failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/pc_sequencer.sv
rtl/fetch_word_hold.sv
rtl/fetch_slot_pack.sv
rtl/fetch_front.sv
sim/fetch_checker.sv
sim/tb_fetch_front.sv

/* Makefile */
# Verilator build and run of the fetch front testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --timing -j 0 --top-module tb_fetch_front -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/Vtb_fetch_front)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
